/* vc_pkg.sv */
// shared definitions for the credit link with the link state encoding and FIFO depth limit

// ---------------------------------------------------------------------------
// link state
// ---------------------------------------------------------------------------

package vc_pkg;

  // bring-up sequence of the link
  // down   -> idle, no traffic, credits may still be arriving
  // train  -> waiting for the full credit pool after enable
  // up     -> traffic allowed while credit is held
  // drain  -> no new traffic, waiting for every credit to come home
  typedef enum logic [1:0]
  {
    LINK_DOWN  = 2'd0,
    LINK_TRAIN = 2'd1,
    LINK_UP    = 2'd2,
    LINK_DRAIN = 2'd3
  } link_state_t;

  // ---------------------------------------------------------------------------
  // sizing
  // ---------------------------------------------------------------------------

  // largest receiver FIFO depth supported
  // counts of slots and credits are sized for this case
  localparam int vc_max_depth = 256;

endpackage

/* vc_credit_counter.sv */
// sender-side count of free receiver slots moved by sends and returned credits

module vc_credit_counter
  (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  take,
    input  logic                                  give,
    output logic [$clog2(vc_pkg::vc_max_depth):0] cr_count,
    output logic                                  credit_avail
  );

  // ---------------------------------------------------------------------------
  // up/down counter
  // ---------------------------------------------------------------------------

  // give = one credit returned by the receiver
  // take = one word accepted, so one slot spent
  // both together cancel out
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cr_count <= '0;
    end
    else
    begin
      case ({give, take})
        2'b10:   cr_count <= cr_count + 1'b1;
        2'b01:   cr_count <= cr_count - 1'b1;
        default: cr_count <= cr_count;
      endcase
    end
  end

  // ---------------------------------------------------------------------------
  // credit test
  // ---------------------------------------------------------------------------

  // nonzero count means the sender may push one more word
  // the only place this condition is decoded
  assign credit_avail = (cr_count != '0);

endmodule

/* vc_link_fsm.sv */
// link FSM that brings the link up through training, runs while enabled and drains on disable

module vc_link_fsm
  #(
    parameter int depth = 16
  )
  (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  link_en,
    input  logic [$clog2(vc_pkg::vc_max_depth):0] cr_count,
    input  logic                                  c_vld,
    output vc_pkg::link_state_t                   link_state
  );

  vc_pkg::link_state_t nxt_state;
  logic                pool_full;

  // every receiver slot is known free on the sender side
  assign pool_full = (cr_count == depth);

  // ---------------------------------------------------------------------------
  // next state
  // ---------------------------------------------------------------------------

  always_comb
  begin
    nxt_state = link_state;
    case (link_state)
      vc_pkg::LINK_DOWN:
      begin
        if (link_en)
          nxt_state = vc_pkg::LINK_TRAIN;
      end
      // credits trickle in one per cycle after reset
      vc_pkg::LINK_TRAIN:
      begin
        if (pool_full)
          nxt_state = vc_pkg::LINK_UP;
      end
      vc_pkg::LINK_UP:
      begin
        if (!link_en)
          nxt_state = vc_pkg::LINK_DRAIN;
      end
      // wait for the last word to land and its credit to return
      vc_pkg::LINK_DRAIN:
      begin
        if (pool_full && !c_vld)
          nxt_state = vc_pkg::LINK_DOWN;
      end
      default:
      begin
        nxt_state = vc_pkg::LINK_DOWN;
      end
    endcase
  end

  // ---------------------------------------------------------------------------
  // state register
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
      link_state <= vc_pkg::LINK_DOWN;
    else
      link_state <= nxt_state;
  end

endmodule

/* vc_sender.sv */
// sender stage taking srdy/drdy words and launching one valid pulse per accepted word

module vc_sender
  #(
    parameter int width = 8
  )
  (
    input  logic                clk,
    input  logic                reset,
    input  vc_pkg::link_state_t link_state,
    input  logic                credit_avail,
    input  logic                s_srdy,
    input  logic [width-1:0]    s_data,
    output logic                s_drdy,
    output logic                take,
    output logic                c_vld,
    output logic [width-1:0]    c_data
  );

  // ---------------------------------------------------------------------------
  // upstream handshake
  // ---------------------------------------------------------------------------

  // only accept while the link runs and a slot is held
  // in train, drain and down the upstream side is stalled
  assign s_drdy = (link_state == vc_pkg::LINK_UP) && credit_avail;

  // word accepted this cycle
  // also spends one credit in the counter
  assign take = s_srdy & s_drdy;

  // ---------------------------------------------------------------------------
  // channel launch
  // ---------------------------------------------------------------------------

  // one valid pulse per accepted word a cycle after acceptance
  always_ff @(posedge clk)
  begin
    if (reset)
      c_vld <= 1'b0;
    else
      c_vld <= take;
  end

  // payload only loads on a transfer
  // holds its last word otherwise
  always_ff @(posedge clk)
  begin
    if (take)
      c_data <= s_data;
  end

endmodule

/* vc_receiver.sv */
// receiver that takes the valid/credit channel into a FIFO and presents it downstream as srdy/drdy

module vc_receiver
  #(
    parameter int depth  = 16,
    parameter int width  = 8,
    parameter int reginp = 0
  )
  (
    input  logic             clk,
    input  logic             reset,
    input  logic             c_vld,
    input  logic [width-1:0] c_data,
    output logic             c_cr,
    output logic             p_srdy,
    output logic [width-1:0] p_data,
    input  logic             p_drdy
  );

  localparam int asz = $clog2(depth);
  localparam int cw  = $clog2(vc_pkg::vc_max_depth) + 1;
  // depth that is not a power of two needs explicit pointer wrap
  localparam bit npt = (depth != (2 ** asz));

  logic [asz:0]       wrptr;
  logic [asz:0]       wrptr_p1;
  logic [asz:0]       nxt_wrptr;
  logic [asz:0]       rdptr;
  logic [asz:0]       rdptr_p1;
  logic [asz:0]       nxt_rdptr;
  logic [cw-1:0]      usage;
  logic [cw-1:0]      nxt_usage;
  logic [cw-1:0]      cissued;
  logic [cw-1:0]      nxt_cissued;
  logic [cw:0]        crtotal;
  logic [cw-1:0]      held;
  logic               full;
  logic               wr_en;
  logic               pop;
  logic               in_vld;
  logic [width-1:0]   wr_data;
  logic               nxt_p_srdy;
  logic [width-1:0]   buffer [depth];

  // ---------------------------------------------------------------------------
  // write side and credit return
  // ---------------------------------------------------------------------------

  assign pop = p_srdy & p_drdy;

  // slots stored plus credits out plus the one going out now
  assign crtotal = {1'b0, usage} + {1'b0, cissued} + (cw + 1)'(c_cr);

  always_comb
  begin
    if (npt && (wrptr == (asz + 1)'(depth - 1)))
      wrptr_p1 = '0;
    else
      wrptr_p1 = wrptr + 1'b1;

    // pow2 depth uses the extra pointer bit and other depths the usage count
    if (npt)
      full = (usage == depth);
    else
      full = (wrptr[asz-1:0] == rdptr[asz-1:0]) && (wrptr[asz] != rdptr[asz]);

    // write blocked on a full FIFO
    wr_en     = in_vld & !full;
    nxt_wrptr = wr_en ? wrptr_p1 : wrptr;

    // credit issued without arrival -> one more out
    // arrival without new credit -> one fewer out
    if (c_cr & !in_vld)
      nxt_cissued = cissued + 1'b1;
    else if (in_vld & !c_cr)
      nxt_cissued = cissued - 1'b1;
    else
      nxt_cissued = cissued;

    if (wr_en & !pop)
      nxt_usage = usage + 1'b1;
    else if (pop & !wr_en)
      nxt_usage = usage - 1'b1;
    else
      nxt_usage = usage;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wrptr   <= '0;
      cissued <= '0;
      usage   <= '0;
      c_cr    <= 1'b0;
    end
    else
    begin
      wrptr   <= nxt_wrptr;
      cissued <= nxt_cissued;
      usage   <= nxt_usage;
      // one credit per cycle until the pool is fully handed out
      c_cr    <= (crtotal < depth);
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
      buffer[wrptr[asz-1:0]] <= wr_data;
  end

  // ---------------------------------------------------------------------------
  // optional input register on the channel
  // ---------------------------------------------------------------------------

  generate
    if (reginp == 1)
    begin : g_reginp
      logic             r_vld;
      logic [width-1:0] r_data;

      always_ff @(posedge clk)
      begin
        if (reset)
          r_vld <= 1'b0;
        else
          r_vld <= c_vld;
      end

      always_ff @(posedge clk)
      begin
        r_data <= c_data;
      end

      assign in_vld  = r_vld;
      assign wr_data = r_data;
    end
    else
    begin : g_direct
      assign in_vld  = c_vld;
      assign wr_data = c_data;
    end
  endgenerate

  // ---------------------------------------------------------------------------
  // read side with look-ahead
  // ---------------------------------------------------------------------------

  always_comb
  begin
    if (npt && (rdptr == (asz + 1)'(depth - 1)))
      rdptr_p1 = '0;
    else
      rdptr_p1 = rdptr + 1'b1;

    nxt_rdptr = pop ? rdptr_p1 : rdptr;

    // words already written and not leaving this cycle
    // usage rather than pointers so a full npt FIFO still shows data
    held       = usage - cw'(pop);
    nxt_p_srdy = (held != '0);
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rdptr  <= '0;
      p_srdy <= 1'b0;
    end
    else
    begin
      rdptr  <= nxt_rdptr;
      p_srdy <= nxt_p_srdy;
    end
  end

  // reading at the next pointer keeps p_data stable while stalled
  always_ff @(posedge clk)
  begin
    p_data <= buffer[nxt_rdptr[asz-1:0]];
  end

endmodule

/* vc_link.sv */
// credit link top level joining sender, credit counter, link FSM and receiver FIFO

module vc_link
  #(
    parameter int depth  = 16,
    parameter int width  = 8,
    parameter int reginp = 0
  )
  (
    input  logic                clk,
    input  logic                reset,
    input  logic                link_en,
    input  logic                s_srdy,
    input  logic [width-1:0]    s_data,
    output logic                s_drdy,
    output logic                p_srdy,
    output logic [width-1:0]    p_data,
    input  logic                p_drdy,
    output vc_pkg::link_state_t link_state
  );

  // ---------------------------------------------------------------------------
  // internal nets
  // ---------------------------------------------------------------------------

  // channel between sender and receiver
  logic                                  c_vld;
  logic [width-1:0]                      c_data;
  logic                                  c_cr;
  // credit bookkeeping
  logic                                  take;
  logic [$clog2(vc_pkg::vc_max_depth):0] cr_count;
  logic                                  credit_avail;

  // ---------------------------------------------------------------------------
  // sender side
  // ---------------------------------------------------------------------------

  vc_sender #(.width(width)) u_sender
  (
    .clk          (clk),
    .reset        (reset),
    .link_state   (link_state),
    .credit_avail (credit_avail),
    .s_srdy       (s_srdy),
    .s_data       (s_data),
    .s_drdy       (s_drdy),
    .take         (take),
    .c_vld        (c_vld),
    .c_data       (c_data)
  );

  // returned credits arrive straight from the receiver
  vc_credit_counter u_credit_counter
  (
    .clk          (clk),
    .reset        (reset),
    .take         (take),
    .give         (c_cr),
    .cr_count     (cr_count),
    .credit_avail (credit_avail)
  );

  vc_link_fsm #(.depth(depth)) u_link_fsm
  (
    .clk        (clk),
    .reset      (reset),
    .link_en    (link_en),
    .cr_count   (cr_count),
    .c_vld      (c_vld),
    .link_state (link_state)
  );

  // ---------------------------------------------------------------------------
  // receiver side
  // ---------------------------------------------------------------------------

  vc_receiver #(.depth(depth), .width(width), .reginp(reginp)) u_receiver
  (
    .clk    (clk),
    .reset  (reset),
    .c_vld  (c_vld),
    .c_data (c_data),
    .c_cr   (c_cr),
    .p_srdy (p_srdy),
    .p_data (p_data),
    .p_drdy (p_drdy)
  );

endmodule

/* tb_vc_link.sv */
// testbench for the credit link with random traffic checked against a queue model

module tb_vc_link;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int depth  = 6;
  localparam int width  = 8;
  localparam int reginp = 1;

  logic                clk;
  logic                reset;
  logic                link_en;
  logic                s_srdy;
  logic [width-1:0]    s_data;
  logic                s_drdy;
  logic                p_srdy;
  logic [width-1:0]    p_data;
  logic                p_drdy;
  vc_pkg::link_state_t link_state;

  // model and run bookkeeping
  logic [width-1:0]    model_q [$];
  vc_pkg::link_state_t prev_state;
  logic                stall_pending;
  logic [width-1:0]    stall_data;
  integer              seed;
  // words handed downstream since the last clear
  int                  delivered;
  string               test_name;

  vc_link #(.depth(depth), .width(width), .reginp(reginp)) dut
  (
    .clk        (clk),
    .reset      (reset),
    .link_en    (link_en),
    .s_srdy     (s_srdy),
    .s_data     (s_data),
    .s_drdy     (s_drdy),
    .p_srdy     (p_srdy),
    .p_data     (p_data),
    .p_drdy     (p_drdy),
    .link_state (link_state)
  );

  // 40 ns clock
  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ---------------------------------------------------------------------------
  // error reporting and compare tasks
  // ---------------------------------------------------------------------------

  task automatic stop_run();
    $display("Errors found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR in %s: %s", test_name, msg);
    stop_run();
  endtask

  task automatic check_data(input string name, input logic [width-1:0] exp,
                            input logic [width-1:0] act);
    if (act !== exp)
    begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_state(input string name, input vc_pkg::link_state_t exp,
                             input vc_pkg::link_state_t act);
    if (act !== exp)
    begin
      $display("MISMATCH %s: expected %s, actual %s", name, exp.name(), act.name());
      stop_run();
    end
  endtask

  // the only legal move out of each state
  function automatic vc_pkg::link_state_t next_link_state(input vc_pkg::link_state_t st);
    case (st)
      vc_pkg::LINK_DOWN:  return vc_pkg::LINK_TRAIN;
      vc_pkg::LINK_TRAIN: return vc_pkg::LINK_UP;
      vc_pkg::LINK_UP:    return vc_pkg::LINK_DRAIN;
      default:            return vc_pkg::LINK_DOWN;
    endcase
  endfunction

  // ---------------------------------------------------------------------------
  // per-cycle monitor and stimulus helpers
  // ---------------------------------------------------------------------------

  // sample mid-cycle and return 2 ns after the next rising edge
  task automatic step_cycle();
    @(negedge clk);
    if (link_state != prev_state)
      check_state(test_name, next_link_state(prev_state), link_state);
    prev_state = link_state;
    // upstream must stall outside the run state
    if (s_drdy && (link_state != vc_pkg::LINK_UP))
      report_error("s_drdy high while link is not up");
    // a stalled downstream word must hold
    if (stall_pending)
    begin
      if (!p_srdy)
        report_error("p_srdy dropped before the word was taken");
      check_data(test_name, stall_data, p_data);
    end
    stall_pending = p_srdy && !p_drdy;
    stall_data    = p_data;
    // delivery first since a word cannot cross in the cycle it is accepted
    if (p_srdy && p_drdy)
    begin
      if (model_q.size() == 0)
        report_error("word delivered downstream with nothing outstanding");
      check_data(test_name, model_q[0], p_data);
      void'(model_q.pop_front());
      delivered++;
    end
    if (s_srdy && s_drdy)
      model_q.push_back(s_data);
    if (model_q.size() > depth)
      report_error("over-run, more than depth words outstanding");
    @(posedge clk);
    #2;
  endtask

  task automatic drive_random();
    logic [31:0] r;
    r      = $random(seed);
    s_srdy = r[0];
    s_data = r[15:8];
    // sink ready about three cycles out of four
    p_drdy = r[1] | r[2];
  endtask

  task automatic wait_state(input vc_pkg::link_state_t target, input int limit);
    int n;
    n = 0;
    while ((link_state != target) && (n < limit))
    begin
      drive_random();
      step_cycle();
      n++;
    end
    if (link_state != target)
      report_error($sformatf("timeout waiting for link state %s", target.name()));
  endtask

  task automatic flush_queue(input int limit);
    int n;
    n = 0;
    s_srdy = 1'b0;
    p_drdy = 1'b1;
    while ((model_q.size() != 0) && (n < limit))
    begin
      step_cycle();
      n++;
    end
    if (model_q.size() != 0)
      report_error("timeout flushing outstanding words");
  endtask

  task automatic run_random(input int cycles);
    repeat (cycles)
    begin
      drive_random();
      step_cycle();
    end
  endtask

  // ---------------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------------

  initial
  begin
    seed          = 48;
    delivered     = 0;
    reset         = 1'b1;
    link_en       = 1'b0;
    s_srdy        = 1'b0;
    s_data        = '0;
    p_drdy        = 1'b0;
    stall_pending = 1'b0;
    stall_data    = '0;
    prev_state    = vc_pkg::LINK_DOWN;
    test_name     = "reset";
    repeat (3) @(posedge clk);
    #2;
    reset   = 1'b0;
    link_en = 1'b1;

    // bring-up with full training after reset
    test_name = "bring_up";
    @(negedge clk);
    check_state(test_name, vc_pkg::LINK_DOWN, link_state);
    if (s_drdy)
      report_error("s_drdy high right after reset");
    @(posedge clk);
    #2;
    check_state(test_name, vc_pkg::LINK_TRAIN, link_state);
    prev_state = link_state;
    wait_state(vc_pkg::LINK_UP, 4 * depth + 20);

    test_name = "data_integrity";
    run_random(400);

    // sink stalled so the sender must stop at depth words
    test_name = "back_pressure";
    p_drdy    = 1'b0;
    repeat (4 * depth + 20)
    begin
      s_srdy = 1'b1;
      s_data = width'($random(seed));
      step_cycle();
    end
    if (model_q.size() != depth)
      report_error("FIFO did not fill to depth under back-pressure");
    if (s_drdy)
      report_error("s_drdy high while the receiver is full");

    test_name = "resume";
    run_random(150);

    // disable while queued words still drain downstream
    test_name = "drain";
    link_en   = 1'b0;
    wait_state(vc_pkg::LINK_DRAIN, 10);
    wait_state(vc_pkg::LINK_DOWN, 400);
    if (model_q.size() != 0)
      report_error("words still outstanding when link went down");

    test_name = "relink";
    delivered = 0;
    link_en   = 1'b1;
    wait_state(vc_pkg::LINK_TRAIN, 10);
    wait_state(vc_pkg::LINK_UP, 4 * depth + 20);
    run_random(300);
    flush_queue(200);
    check_state(test_name, vc_pkg::LINK_UP, link_state);
    if (delivered == 0)
      report_error("no words crossed the link after relink");

    $display("No errors");
    $finish;
  end

endmodule

/* verilog.f */
vc_pkg.sv
vc_credit_counter.sv
vc_link_fsm.sv
vc_sender.sv
vc_receiver.sv
vc_link.sv
tb_vc_link.sv

/* Bender.yml */
package:
  name: vc_link

sources:
  - vc_pkg.sv
  - vc_credit_counter.sv
  - vc_link_fsm.sv
  - vc_sender.sv
  - vc_receiver.sv
  - vc_link.sv
  - target: test
    files:
      - tb_vc_link.sv
